// File: hdl/adc_pkg.sv
`default_nettype none

// ---------------------------------------------------------------------------
// ADC word format
// ---------------------------------------------------------------------------
package adc_pkg;

    localparam int ADC_WORD_W = 14;        // One raw word from the converter
    localparam int SAMPLE_W   = 12;        // Sample field, low bits
    localparam int INFO_W     = 2;         // Info field, top bits of the word

    // Field view of a lane word
    typedef struct packed {
        logic [INFO_W-1:0]   info;         // Bits 13:12
        logic [SAMPLE_W-1:0] sample;       // Bits 11:0
    } adc_fields_t;

    // Lanes move raw words; packer reads fields
    typedef union packed {
        logic [ADC_WORD_W-1:0] raw;
        adc_fields_t           fields;
    } adc_word_u;

endpackage

`default_nettype wire

// File: hdl/capture_cfg_pkg.sv
`default_nettype none

// ---------------------------------------------------------------------------
// Capture geometry, fixed by the ADC format
// ---------------------------------------------------------------------------
package capture_cfg_pkg;

    localparam int NUM_LANES        = 4;                       // ADC data lanes
    localparam int FRAME_LEN        = 4;                       // Words per lane per frame
    localparam int LANES_PER_RAIL   = NUM_LANES / 2;           // Lanes 0,1 I; lanes 2,3 Q
    localparam int SAMPLES_PER_RAIL = LANES_PER_RAIL * FRAME_LEN;
    localparam int DELAY_W          = 4;                       // Taps 0 to 15
    localparam int DELAY_DEPTH      = 1 << DELAY_W;            // Delay line length
    localparam int DROP_W           = 16;                      // Dropped frame counter

    // Slot index inside a frame
    typedef logic [$clog2(FRAME_LEN)-1:0] word_idx_t;

endpackage

`default_nettype wire

// File: hdl/capture_ctrl_if.sv
`timescale 1ns/100ps
`default_nettype none

// Control from capture_ctrl out to the datapath blocks
interface capture_ctrl_if
    import capture_cfg_pkg::*;
    ();

    logic [DELAY_W-1:0]   delay_val;       // Registered tap value, common to all lanes
    logic [NUM_LANES-1:0] load_mask;       // Per-lane tap load strobe
    word_idx_t            word_idx;        // Slot for the word presented this cycle
    logic                 word_en;         // Delayed word valid at deserializers
    logic                 capture;         // Frame complete, recapture it
    logic                 out_load;        // Move recaptured frame to output regs

    // Control source
    modport ctrl (
        output delay_val, load_mask, word_idx, word_en, capture, out_load
    );

    // Lane delay lines
    modport delay (input delay_val, load_mask);

    // Lane deserializers
    modport deser (input word_idx, word_en);

    // Recapture and output stage
    modport packer (input capture, out_load);

endinterface

`default_nettype wire

// File: hdl/capture_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module capture_ctrl
    import capture_cfg_pkg::*;
(
    input  wire logic               clk_0,
    input  wire logic               reset,
    input  wire logic               in_valid,        // ADC word strobe, cannot stall
    input  wire logic [DELAY_W-1:0] dly_val,         // User tap value
    input  wire logic [NUM_LANES-1:0] load_dly,      // User lane load mask
    input  wire logic               out_ready,       // Downstream accepts
    output logic                    out_valid,
    output logic [DROP_W-1:0]       dropped_frames,
    capture_ctrl_if.ctrl            ctrl_bus
);

    localparam word_idx_t LAST_SLOT = word_idx_t'(FRAME_LEN - 1);

    logic [DELAY_W-1:0]   dly_val_r;       // Fanout copy of tap value
    logic [NUM_LANES-1:0] load_mask_r;     // Fanout copy of load mask
    word_idx_t            slot_cnt;        // Slot of the word at the input
    word_idx_t            word_idx_r;      // Slot of the word leaving the delay lines
    logic                 word_en_r;
    logic                 capture_r;
    logic                 pend_r;          // Recaptured frame waiting for load or drop
    logic                 out_load;
    logic                 drop;

    // ------------------------------------------------------------------------
    // Delay command fanout
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_0)
    begin
        if (reset)
        begin
            dly_val_r   <= '0;
            load_mask_r <= '0;
        end
        else
        begin
            dly_val_r   <= dly_val;
            load_mask_r <= load_dly;       // Lanes load one cycle later
        end
    end

    // ------------------------------------------------------------------------
    // Frame slot counter and capture strobe
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_0)
    begin
        if (reset)
        begin
            slot_cnt   <= '0;              // First valid word is slot 0
            word_idx_r <= '0;
            word_en_r  <= 1'b0;
            capture_r  <= 1'b0;
            pend_r     <= 1'b0;
        end
        else
        begin
            if (in_valid)
                slot_cnt <= (slot_cnt == LAST_SLOT) ? '0 : slot_cnt + 1'b1;
            word_en_r  <= in_valid;        // Word shows at delay output next cycle
            word_idx_r <= slot_cnt;
            capture_r  <= word_en_r && (word_idx_r == LAST_SLOT);  // Slot 3 written
            pend_r     <= capture_r;       // Decide one cycle after recapture
        end
    end

    // Load when output is empty or emptying now, else the frame is lost
    assign out_load = pend_r && (!out_valid || out_ready);
    assign drop     = pend_r && out_valid && !out_ready;

    // ------------------------------------------------------------------------
    // Output handshake and drop count
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_0)
    begin
        if (reset)
        begin
            out_valid      <= 1'b0;
            dropped_frames <= '0;
        end
        else
        begin
            if (out_load)
                out_valid <= 1'b1;
            else if (out_ready)
                out_valid <= 1'b0;         // Transfer done, nothing new
            if (drop && (dropped_frames != {DROP_W{1'b1}}))
                dropped_frames <= dropped_frames + 1'b1;  // Saturates
        end
    end

    assign ctrl_bus.delay_val = dly_val_r;
    assign ctrl_bus.load_mask = load_mask_r;
    assign ctrl_bus.word_idx  = word_idx_r;
    assign ctrl_bus.word_en   = word_en_r;
    assign ctrl_bus.capture   = capture_r;
    assign ctrl_bus.out_load  = out_load;

endmodule

`default_nettype wire

// File: hdl/lane_delay.sv
`timescale 1ns/100ps
`default_nettype none

// Loadable delay for one lane, counted in valid words
module lane_delay
    import adc_pkg::*;
    import capture_cfg_pkg::*;
(
    input  wire logic      clk_0,
    input  wire logic      reset,
    input  wire logic      load_en,        // This lane's load_mask bit
    input  wire adc_word_u word_in,        // Raw word from the ADC pins
    input  wire logic      in_valid,
    capture_ctrl_if.delay  ctrl_bus,
    output adc_word_u      word_out        // Word from the selected tap
);

    adc_word_u [DELAY_DEPTH-1:0] line_sr;  // Index 0 is the newest word
    logic [DELAY_W-1:0]          tap;

    // Tap register
    always_ff @(posedge clk_0)
    begin
        if (reset)
            tap <= '0;
        else if (load_en)
            tap <= ctrl_bus.delay_val;     // Takes effect next cycle
    end

    // Shift only on valid words
    always_ff @(posedge clk_0)
    begin
        if (in_valid)
            line_sr <= {line_sr[DELAY_DEPTH-2:0], word_in};
    end

    // Tap 0 gives the word taken on the last valid cycle
    assign word_out = line_sr[tap];

endmodule

`default_nettype wire

// File: hdl/lane_deserializer.sv
`timescale 1ns/100ps
`default_nettype none

// Gathers FRAME_LEN consecutive words of one lane
module lane_deserializer
    import adc_pkg::*;
    import capture_cfg_pkg::*;
(
    input  wire logic      clk_0,
    input  wire logic      reset,
    input  wire adc_word_u word_in,        // From the lane delay line
    capture_ctrl_if.deser  ctrl_bus,
    output adc_word_u [FRAME_LEN-1:0] frame  // Slot 0 earliest, slot 3 latest
);

    // ------------------------------------------------------------------------
    // Slot write
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_0)
    begin
        if (reset)
        begin
            frame <= '0;                   // All slots cleared
        end
        else if (ctrl_bus.word_en)
        begin
            // Slot comes from the common counter, so lanes stay aligned
            frame[ctrl_bus.word_idx] <= word_in;
        end
    end

endmodule

`default_nettype wire

// File: hdl/sample_packer.sv
`timescale 1ns/100ps
`default_nettype none

// Recapture of all lane frames, then split into I/Q samples and info
module sample_packer
    import adc_pkg::*;
    import capture_cfg_pkg::*;
(
    input  wire logic      clk_0,
    input  wire logic      reset,
    input  wire adc_word_u [NUM_LANES-1:0][FRAME_LEN-1:0] lane_frame,
    capture_ctrl_if.packer ctrl_bus,
    output logic [SAMPLES_PER_RAIL-1:0][SAMPLE_W-1:0] sample_i,
    output logic [SAMPLES_PER_RAIL-1:0][INFO_W-1:0]   info_i,
    output logic [SAMPLES_PER_RAIL-1:0][SAMPLE_W-1:0] sample_q,
    output logic [SAMPLES_PER_RAIL-1:0][INFO_W-1:0]   info_q
);

    adc_word_u [NUM_LANES-1:0][FRAME_LEN-1:0] recap;  // Frame held for the load decision

    // ------------------------------------------------------------------------
    // Recapture stage
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_0)
    begin
        if (ctrl_bus.capture)
            recap <= lane_frame;           // Deserializers free to refill
    end

    // ------------------------------------------------------------------------
    // Output registers
    // ------------------------------------------------------------------------
    // Lane l slot t goes to rail index (l mod LANES_PER_RAIL) * FRAME_LEN + t
    always_ff @(posedge clk_0)
    begin
        if (reset)
        begin
            sample_i <= '0;
            info_i   <= '0;
            sample_q <= '0;
            info_q   <= '0;
        end
        else if (ctrl_bus.out_load)
        begin
            for (int l = 0; l < LANES_PER_RAIL; l++)
            begin
                for (int t = 0; t < FRAME_LEN; t++)
                begin
                    // I rail from lanes 0 and 1
                    sample_i[l*FRAME_LEN+t] <= recap[l][t].fields.sample;
                    info_i[l*FRAME_LEN+t]   <= recap[l][t].fields.info;
                    // Q rail from lanes 2 and 3
                    sample_q[l*FRAME_LEN+t] <= recap[l+LANES_PER_RAIL][t].fields.sample;
                    info_q[l*FRAME_LEN+t]   <= recap[l+LANES_PER_RAIL][t].fields.info;
                end
            end
        end
        // Held while out_valid waits for out_ready
    end

endmodule

`default_nettype wire

// File: hdl/adc_capture_top.sv
`timescale 1ns/100ps
`default_nettype none

module adc_capture_top
    import adc_pkg::*;
    import capture_cfg_pkg::*;
(
    input  wire logic                  clk_0,
    input  wire logic                  reset,
    // ADC side
    input  wire adc_word_u [NUM_LANES-1:0] lane_word,   // One raw word per lane
    input  wire logic                  in_valid,
    // Delay control
    input  wire logic [DELAY_W-1:0]    dly_val,
    input  wire logic [NUM_LANES-1:0]  load_dly,        // Lane mask
    // Sample output
    input  wire logic                  out_ready,
    output logic [SAMPLES_PER_RAIL-1:0][SAMPLE_W-1:0] sample_i,
    output logic [SAMPLES_PER_RAIL-1:0][SAMPLE_W-1:0] sample_q,
    output logic [SAMPLES_PER_RAIL-1:0][INFO_W-1:0]   info_i,
    output logic [SAMPLES_PER_RAIL-1:0][INFO_W-1:0]   info_q,
    output logic                       out_valid,
    output logic [DROP_W-1:0]          dropped_frames
);

    adc_word_u [NUM_LANES-1:0]                dly_word;     // Delay line outputs
    adc_word_u [NUM_LANES-1:0][FRAME_LEN-1:0] lane_frame;   // Deserialized frames

    capture_ctrl_if ctrl_bus ();

    // ------------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------------
    capture_ctrl capture_ctrl_i (
        .clk_0          (clk_0),
        .reset          (reset),
        .in_valid       (in_valid),
        .dly_val        (dly_val),
        .load_dly       (load_dly),
        .out_ready      (out_ready),
        .out_valid      (out_valid),
        .dropped_frames (dropped_frames),
        .ctrl_bus       (ctrl_bus)
    );

    // ------------------------------------------------------------------------
    // Per-lane delay and deserializer
    // ------------------------------------------------------------------------
    for (genvar g = 0; g < NUM_LANES; g++)
    begin : g_lane
        lane_delay lane_delay_i (
            .clk_0    (clk_0),
            .reset    (reset),
            .load_en  (ctrl_bus.load_mask[g]),   // Own bit of the fanout mask
            .word_in  (lane_word[g]),
            .in_valid (in_valid),
            .ctrl_bus (ctrl_bus),
            .word_out (dly_word[g])
        );

        lane_deserializer lane_deserializer_i (
            .clk_0    (clk_0),
            .reset    (reset),
            .word_in  (dly_word[g]),
            .ctrl_bus (ctrl_bus),
            .frame    (lane_frame[g])
        );
    end

    // ------------------------------------------------------------------------
    // Recapture and I/Q split
    // ------------------------------------------------------------------------
    sample_packer sample_packer_i (
        .clk_0      (clk_0),
        .reset      (reset),
        .lane_frame (lane_frame),
        .ctrl_bus   (ctrl_bus),
        .sample_i   (sample_i),
        .info_i     (info_i),
        .sample_q   (sample_q),
        .info_q     (info_q)
    );

endmodule

`default_nettype wire

// File: dv/tb_adc_capture.sv
`timescale 1ns/100ps
`default_nettype none

module tb_adc_capture
    import adc_pkg::*;
    import capture_cfg_pkg::*;
    ();

    localparam int CLK_PERIOD  = 8;
    localparam int RESET_CYC   = 8;
    localparam int MAP_CYC     = 300;             // Taps all at 0
    localparam int SETTLE_CYC  = 40;              // Frames ignored after a tap load
    localparam int DELAY_CYC   = 200;
    localparam int STALL_MAX   = 16 + 63;         // Longest out_ready low stretch
    localparam int DRAIN_CYC   = 200;
    localparam int PULSE_CYC   = 3;               // Mid-run reset pulse
    localparam int POST_CYC    = 150;
    localparam int RUN_CYC     = RESET_CYC + MAP_CYC + 1 + SETTLE_CYC + DELAY_CYC
                                 + STALL_MAX + DRAIN_CYC + PULSE_CYC + POST_CYC + 2;
    localparam int WATCHDOG_NS = (RUN_CYC + 200) * CLK_PERIOD;
    localparam int HOLD_W      = 1 + 2 * SAMPLES_PER_RAIL * (SAMPLE_W + INFO_W);

    logic                      clk_0 = 1'b0;
    logic                      reset;
    adc_word_u [NUM_LANES-1:0] lane_word;
    logic                      in_valid;
    logic [DELAY_W-1:0]        dly_val;
    logic [NUM_LANES-1:0]      load_dly;
    logic                      out_ready;
    logic [SAMPLES_PER_RAIL-1:0][SAMPLE_W-1:0] sample_i, sample_q;
    logic [SAMPLES_PER_RAIL-1:0][INFO_W-1:0]   info_i, info_q;
    logic                      out_valid;
    logic [DROP_W-1:0]         dropped_frames;

    // Stimulus state
    logic [31:0]         lfsr;
    logic [31:0]         rnd;
    logic [SAMPLE_W-1:0] word_cnt;                // Running sample counter on every lane
    int                  ready_mode;              // 1 random, 2 held low
    logic [DELAY_W-1:0]  lane2_tap;               // Tap the model expects on lane 2
    logic                map_en;
    string               phase_name;

    // Output snapshot from the previous falling edge
    logic                snap_valid;
    logic [SAMPLES_PER_RAIL-1:0][SAMPLE_W-1:0] snap_si, snap_sq;
    logic [SAMPLES_PER_RAIL-1:0][INFO_W-1:0]   snap_ii, snap_iq;
    int                  since_rst;
    logic                have_last;
    logic [SAMPLE_W-1:0] last_i0;
    logic [DROP_W-1:0]   last_drops, frame_drops; // Drop count when a frame loaded

    // Check operands held stable from falling edge to falling edge
    logic rst_chk, map_chk, hold_chk, drop_chk;
    logic rst_valid;
    logic [DROP_W-1:0]   rst_drops;
    logic [SAMPLES_PER_RAIL-1:0][SAMPLE_W-1:0] exp_si, act_si, exp_sq, act_sq;
    logic [2*SAMPLES_PER_RAIL*INFO_W-1:0]      exp_info, act_info;
    logic [HOLD_W-1:0]   hold_exp, hold_act;
    int                  drop_exp, drop_act;
    int                  err_reset, err_map, err_hold, err_drop;

    always #(CLK_PERIOD / 2) clk_0 = ~clk_0;

    adc_capture_top adc_capture_top_i (
        .clk_0 (clk_0), .reset (reset), .lane_word (lane_word), .in_valid (in_valid),
        .dly_val (dly_val), .load_dly (load_dly), .out_ready (out_ready),
        .sample_i (sample_i), .sample_q (sample_q), .info_i (info_i), .info_q (info_q),
        .out_valid (out_valid), .dropped_frames (dropped_frames)
    );

    // ------------------------------------------------------------------------
    // Random bits from a Fibonacci LFSR with taps 32, 22, 2, 1
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int b = 0; b < n; b++)
        begin
            bits = {bits[30:0], lfsr[31]};     // One step per bit
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Derives expected values from what the last rising edge did
    task automatic observe();
        logic                acc;
        logic                load;
        logic [SAMPLE_W-1:0] delta;
        acc  = snap_valid && out_ready && !reset;            // Transfer at last edge
        load = out_valid && (!snap_valid || acc) && !reset;  // New frame at last edge
        since_rst = reset ? 0 : ((since_rst < 1000) ? since_rst + 1 : since_rst);
        rst_chk   = reset || (since_rst < 6);                // Too early for any frame
        rst_valid = out_valid;
        rst_drops = dropped_frames;
        hold_chk  = snap_valid && !out_ready && !reset;
        hold_exp  = {snap_valid, snap_si, snap_sq, snap_ii, snap_iq};
        hold_act  = {out_valid, sample_i, sample_q, info_i, info_q};
        // Lane mapping and lane 2 delay
        map_chk  = acc && map_en;
        act_si   = snap_si;
        act_sq   = snap_sq;
        act_info = {snap_iq, snap_ii};
        for (int k = 0; k < SAMPLES_PER_RAIL; k++)
        begin
            exp_si[k] = snap_si[0] + SAMPLE_W'(k % FRAME_LEN);   // Every group starts at i0
            exp_sq[k] = exp_si[k] - ((k < FRAME_LEN) ? SAMPLE_W'(lane2_tap) : SAMPLE_W'(0));
            exp_info[k*INFO_W +: INFO_W] = INFO_W'(k / FRAME_LEN);
            exp_info[(SAMPLES_PER_RAIL+k)*INFO_W +: INFO_W] = INFO_W'(2 + k / FRAME_LEN);
        end
        // Skipped words between accepted frames must all be counted drops
        drop_chk = 1'b0;
        if (reset)
            have_last = 1'b0;
        else if (acc)
        begin
            if (have_last)
            begin
                delta    = snap_si[0] - last_i0;
                drop_exp = int'(delta) / FRAME_LEN - 1;
                drop_act = int'(frame_drops) - int'(last_drops);
                drop_chk = 1'b1;
            end
            have_last  = 1'b1;
            last_i0    = snap_si[0];
            last_drops = frame_drops;
        end
        if (load)
            frame_drops = dropped_frames;
        snap_valid = out_valid;
        snap_si    = sample_i;
        snap_sq    = sample_q;
        snap_ii    = info_i;
        snap_iq    = info_q;
    endtask

    task automatic drive_lanes();
        logic [31:0] r;
        if (reset)
        begin
            in_valid = 1'b0;
            word_cnt = '0;                      // First word after reset is 0
        end
        else
        begin
            take_bits(2, r);
            in_valid = (r[1:0] != 2'b00);      // Gaps a quarter of the time
        end
        for (int l = 0; l < NUM_LANES; l++)
        begin
            lane_word[l].fields.info   = INFO_W'(l);
            lane_word[l].fields.sample = word_cnt;
        end
        if (in_valid)
            word_cnt = word_cnt + 1'b1;
        if (ready_mode == 1)
        begin
            take_bits(1, r);
            out_ready = r[0];
        end
        else
            out_ready = 1'b0;                   // Downstream stalled
    endtask

    task automatic run_cycles(input int n);
        repeat (n)
        begin
            @(negedge clk_0);
            observe();
            drive_lanes();
        end
    endtask

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    reset_state_a: assert property (@(posedge clk_0) rst_chk |-> (!rst_valid && rst_drops == '0))
        else
        begin
            err_reset++;
            $display("ERR %s reset_state: expected out_valid 0 dropped_frames 0, actual %0d %0d",
                     phase_name, rst_valid, rst_drops);
        end
    info_map_a: assert property (@(posedge clk_0) map_chk |-> (act_info == exp_info))
        else
        begin
            err_map++;
            $display("ERR %s info_map: expected %h actual %h", phase_name, exp_info, act_info);
        end
    i_rail_a: assert property (@(posedge clk_0) map_chk |-> (act_si == exp_si))
        else
        begin
            err_map++;
            $display("ERR %s i_rail: expected %h actual %h", phase_name, exp_si, act_si);
        end
    q_rail_a: assert property (@(posedge clk_0) map_chk |-> (act_sq == exp_sq))
        else
        begin
            err_map++;
            $display("ERR %s q_rail: expected %h actual %h", phase_name, exp_sq, act_sq);
        end
    hold_a: assert property (@(posedge clk_0) hold_chk |-> (hold_act == hold_exp))
        else
        begin
            err_hold++;
            $display("ERR %s hold: expected %h actual %h", phase_name, hold_exp, hold_act);
        end
    drop_count_a: assert property (@(posedge clk_0) drop_chk |-> (drop_act == drop_exp))
        else
        begin
            err_drop++;
            $display("ERR %s drop_count: expected %0d actual %0d", phase_name, drop_exp, drop_act);
        end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog: run still going after %0d ns, stopped", WATCHDOG_NS);
        $display("** FAIL **");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Phases
    // ------------------------------------------------------------------------
    initial
    begin
        lfsr = 32'h775c;
        reset = 1'b1;
        lane_word = '0;
        in_valid = 1'b0;
        dly_val = '0;
        load_dly = '0;
        out_ready = 1'b0;
        word_cnt = '0;
        ready_mode = 1;
        lane2_tap = '0;
        map_en = 1'b1;
        {snap_valid, snap_si, snap_sq, snap_ii, snap_iq} = '0;
        since_rst = 0;
        have_last = 1'b0;
        {last_i0, last_drops, frame_drops} = '0;
        {rst_chk, map_chk, hold_chk, drop_chk} = '0;
        {err_reset, err_map, err_hold, err_drop} = '0;
        phase_name = "reset";
        run_cycles(RESET_CYC);
        reset = 1'b0;
        phase_name = "lane_map";
        run_cycles(MAP_CYC);
        phase_name = "lane_delay";               // Tap on lane 2 only
        take_bits(DELAY_W, rnd);
        dly_val  = (rnd[DELAY_W-1:0] == '0) ? DELAY_W'(1) : rnd[DELAY_W-1:0];
        load_dly = 4'b0100;
        map_en   = 1'b0;                         // Words in flight are undefined
        run_cycles(1);
        load_dly = '0;
        run_cycles(SETTLE_CYC);
        lane2_tap = dly_val;
        map_en    = 1'b1;
        run_cycles(DELAY_CYC);
        phase_name = "drop_count";
        take_bits(6, rnd);
        ready_mode = 2;                          // Downstream stalls so frames drop
        run_cycles(16 + int'(rnd[5:0]));
        ready_mode = 1;
        run_cycles(DRAIN_CYC);
        phase_name = "mid_reset";
        reset     = 1'b1;
        lane2_tap = '0;                          // Taps return to 0
        run_cycles(PULSE_CYC);
        reset = 1'b0;
        run_cycles(POST_CYC);
        @(posedge clk_0);
        @(negedge clk_0);
        $display("Errors: reset_state %0d, lane_map %0d, hold %0d, drop_count %0d",
                 err_reset, err_map, err_hold, err_drop);
        if (err_reset + err_map + err_hold + err_drop == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
hdl/adc_pkg.sv
hdl/capture_cfg_pkg.sv
hdl/capture_ctrl_if.sv
hdl/capture_ctrl.sv
hdl/lane_delay.sv
hdl/lane_deserializer.sv
hdl/sample_packer.sv
hdl/adc_capture_top.sv
dv/tb_adc_capture.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ADC capture testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_adc_capture \
    -f list.f -o sim_adc_capture
./obj_dir/sim_adc_capture > sim.log 2>&1
cat sim.log

# Verdict comes from the log
if grep -Fqx '** PASS **' sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed, see sim.log"
exit 1
